// ==== Bender.yml ====
package:
  name: heapMemory

sources:
  - include_dirs:
      - src
    files:
      - src/heapOpPkg.sv
      - src/heapStorePkg.sv
      - src/heapCommand_if.sv
      - src/heapAllocator.sv
      - src/heapArrayUnit.sv
      - src/heapMemory.sv
  - target: test
    files:
      - tb/heapMemory_props.sv
      - tb/heapMemory_tb.sv

// ==== heapMemory.f ====
+incdir+src
src/heapOpPkg.sv
src/heapStorePkg.sv
src/heapCommand_if.sv
src/heapAllocator.sv
src/heapArrayUnit.sv
src/heapMemory.sv
tb/heapMemory_props.sv
tb/heapMemory_tb.sv

// ==== src/heapAllocator.sv ====
//----------------------------------------------------------------------
// Allocation state of the heap: live bits, freed stack, fresh counter
// Judges every command against it and updates it on the result edge
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "heapMemory_params.svh"

module heapAllocator import heapOpPkg::*, heapStorePkg::*; (
  input logic              clock,
  input logic              resetN,
  heapCommand_if.allocator cmd
);

  typedef logic [`HEAP_ARRAY_BITS:0] countT;   // 0 up to numArrays

  logic [numArrays-1:0] allocated;       // Currently granted
  logic [numArrays-1:0] granted;         // Granted since last clear
  arrayIdT              freedStack [numArrays];
  countT                freedTop;        // Entries on the freed stack
  countT                freshCount;      // Next never-used array

  logic    stackUsed;
  logic    freshFull;
  arrayIdT topId;
  logic    commit;

  assign stackUsed = freedTop != '0;
  assign freshFull = freshCount[`HEAP_ARRAY_BITS];  // Counter stops at numArrays
  assign topId     = arrayIdT'(freedTop - 1'b1);
  assign commit    = cmd.valid && cmd.allocError == ErrNone;

  assign cmd.neverUsed = !granted[cmd.array];
  assign cmd.live      = allocated[cmd.array];

  // ----------------------------------------------------------------------
  // Verdict on the registered command
  // ----------------------------------------------------------------------
  always_comb begin
    cmd.allocatedId = '0;
    cmd.allocError  = ErrNone;
    case (cmd.op)
      OpNone, OpClearAll: cmd.allocError = ErrNone;
      OpAlloc: begin
        if (stackUsed) begin
          cmd.allocatedId = freedStack[topId];   // Most recently freed
        end else if (!freshFull) begin
          cmd.allocatedId = arrayIdT'(freshCount);
        end else begin
          cmd.allocError = ErrOutOfMemory;
        end
      end
      default: begin
        if (cmd.neverUsed) begin
          cmd.allocError = ErrNotAllocated;
        end else if (!cmd.live) begin
          cmd.allocError = ErrFreed;
        end
      end
    endcase
  end

  // ----------------------------------------------------------------------
  // State update, same edge as the result register
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocated  <= '0;
      granted    <= '0;
      freedTop   <= '0;
      freshCount <= '0;
    end else if (commit) begin
      case (cmd.op)
        OpClearAll: begin
          allocated  <= '0;
          granted    <= '0;
          freedTop   <= '0;
          freshCount <= '0;
        end
        OpAlloc: begin
          allocated[cmd.allocatedId] <= 1'b1;
          granted[cmd.allocatedId]   <= 1'b1;
          if (stackUsed) begin
            freedTop <= freedTop - 1'b1;
          end else begin
            freshCount <= freshCount + 1'b1;
          end
        end
        OpFree: begin
          allocated[cmd.array] <= 1'b0;
          freedTop             <= freedTop + 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (commit && cmd.op == OpFree) begin
      freedStack[arrayIdT'(freedTop)] <= cmd.array;  // Push onto free stack
    end
  end

endmodule

`default_nettype wire

// ==== src/heapArrayUnit.sv ====
//----------------------------------------------------------------------
// Element storage and size table of the heap
// Runs each element op, applies range rules and registers the result
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapArrayUnit import heapOpPkg::*, heapStorePkg::*; (
  input  logic            clock,
  input  logic            resetN,
  heapCommand_if.executor cmd,
  output logic            done,
  output dataT            dataOut,
  output heapErrT         error
);

  dataT mem   [numArrays][arrayLength];  // Element storage
  sizeT sizes [numArrays];               // Current size per array

  arrayIdT target;                       // Array whose state changes
  sizeT    curSize;
  dataT    elem;
  dataT    popElem;
  logic    inRange;

  heapErrT errNext;
  dataT    resultNext;
  logic    writeEn;
  indexT   writeIdx;
  dataT    writeData;
  logic    sizeEn;
  sizeT    sizeNext;

  assign target  = (cmd.op == OpAlloc) ? cmd.allocatedId : cmd.array;
  assign curSize = sizes[cmd.array];
  assign elem    = mem[cmd.array][cmd.index];
  assign popElem = mem[cmd.array][indexT'(curSize - 1'b1)];
  assign inRange = sizeT'(cmd.index) < curSize;

  // ----------------------------------------------------------------------
  // Operation decode
  // ----------------------------------------------------------------------
  always_comb begin
    errNext    = ErrNone;
    resultNext = '0;
    writeEn    = 1'b0;
    writeIdx   = cmd.index;
    writeData  = cmd.dataIn;
    sizeEn     = 1'b0;
    sizeNext   = curSize;
    if (cmd.allocError != ErrNone) begin
      errNext = cmd.allocError;            // Allocator verdict wins
    end else begin
      case (cmd.op)
        OpAlloc: begin
          sizeEn     = 1'b1;                // Granted array starts empty
          sizeNext   = '0;
          resultNext = dataT'(cmd.allocatedId);
        end
        OpWrite: begin
          writeEn    = 1'b1;
          resultNext = cmd.dataIn;
          if (!inRange) begin
            sizeEn   = 1'b1;                // Extend past the end
            sizeNext = sizeT'(cmd.index) + 1'b1;
          end
        end
        OpRead: begin
          if (inRange) resultNext = elem;
          else errNext = ErrOutOfBounds;
        end
        OpSize: resultNext = dataT'(curSize);
        OpPush: begin
          if (curSize == sizeT'(arrayLength)) begin
            errNext = ErrFull;
          end else begin
            writeEn    = 1'b1;
            writeIdx   = indexT'(curSize);
            sizeEn     = 1'b1;
            sizeNext   = curSize + 1'b1;
            resultNext = cmd.dataIn;
          end
        end
        OpPop: begin
          if (curSize == '0) begin
            errNext = ErrEmpty;
          end else begin
            sizeEn     = 1'b1;
            sizeNext   = curSize - 1'b1;
            resultNext = popElem;          // Element at the new size
          end
        end
        OpResize: begin
          if (cmd.dataIn > dataT'(arrayLength)) begin
            errNext = ErrTooLarge;
          end else begin
            sizeEn     = 1'b1;
            sizeNext   = sizeT'(cmd.dataIn);
            resultNext = cmd.dataIn;
          end
        end
        OpAdd, OpSubtract: begin
          if (inRange) begin
            writeEn    = 1'b1;
            writeData  = (cmd.op == OpAdd) ? elem + cmd.dataIn : elem - cmd.dataIn;
            resultNext = writeData;        // Wraps at data width
          end else begin
            errNext = ErrOutOfBounds;
          end
        end
        default: ;                         // Free, ClearAll give 0
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Storage, sizes and result registers
  // ----------------------------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      mem   <= '{default: '0};
      sizes <= '{default: '0};
    end else if (cmd.valid) begin
      if (writeEn) mem[cmd.array][writeIdx] <= writeData;
      if (sizeEn) sizes[target] <= sizeNext;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done    <= 1'b0;
      dataOut <= '0;
      error   <= ErrNone;
    end else begin
      done <= cmd.valid;
      if (cmd.valid) begin
        dataOut <= resultNext;
        error   <= errNext;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/heapCommand_if.sv ====
//----------------------------------------------------------------------
// Registered heap command plus the allocator's verdict on it
// Driven by the top, checked by the allocator, run by the array unit
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface heapCommand_if import heapOpPkg::*, heapStorePkg::*; ();

  logic    valid;                        // One cycle per command
  heapOpT  op;
  arrayIdT array;
  indexT   index;
  dataT    dataIn;

  logic    live;                         // Allocated and not freed
  heapErrT allocError;                   // Verdict for the current op
  arrayIdT allocatedId;                  // Grant of an Alloc
  logic    neverUsed;                    // Not granted since clear

  modport source (output valid, op, array, index, dataIn);

  modport allocator (
    input  valid, op, array,
    output live, allocError, allocatedId, neverUsed
  );

  modport executor (
    input valid, op, array, index, dataIn,
    input live, allocError, allocatedId, neverUsed
  );

endinterface

`default_nettype wire

// ==== src/heapMemory.sv ====
//----------------------------------------------------------------------
// Heap memory top: one command per start strobe, result 2 cycles on
// Registers the command, then allocator and array unit finish it
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapMemory import heapOpPkg::*, heapStorePkg::*; (
  input  logic    clock,
  input  logic    resetN,
  input  logic    start,                 // One-cycle command strobe
  input  heapOpT  op,
  input  arrayIdT array,
  input  indexT   index,
  input  dataT    dataIn,
  output logic    done,                  // Result pulse
  output dataT    dataOut,
  output heapErrT error
);

  heapCommand_if cmd ();

  // Command register stage
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      cmd.valid <= 1'b0;
      cmd.op    <= OpNone;
    end else begin
      cmd.valid <= start;
      if (start) cmd.op <= op;
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      cmd.array  <= array;
      cmd.index  <= index;
      cmd.dataIn <= dataIn;
    end
  end

  heapAllocator allocator0 (.clock, .resetN, .cmd(cmd));

  heapArrayUnit arrayUnit0 (.clock, .resetN, .cmd(cmd), .done, .dataOut, .error);

endmodule

`default_nettype wire

// ==== src/heapMemory_params.svh ====
//----------------------------------------------------------------------
// Heap geometry shared by the packages and the RTL
// Include wherever array, index or data widths are needed
//----------------------------------------------------------------------
`ifndef HEAP_MEMORY_PARAMS_SVH
`define HEAP_MEMORY_PARAMS_SVH

// Bits in an array number, 4 arrays
`define HEAP_ARRAY_BITS 2

// Bits in an element index, 8 elements per array
`define HEAP_INDEX_BITS 3

`define HEAP_DATA_BITS 12                // Width of one element

`endif

// ==== src/heapOpPkg.sv ====
//----------------------------------------------------------------------
// Command and outcome types of the heap memory
// Opcode values are fixed and sparse, error codes run in sequence
//----------------------------------------------------------------------
`default_nettype none

package heapOpPkg;

  typedef enum logic [4:0] {
    OpNone     = 5'd0,                   // Idle, no effect
    OpClearAll = 5'd1,                   // Forget every allocation
    OpWrite    = 5'd2,
    OpRead     = 5'd3,
    OpSize     = 5'd4,
    OpPush     = 5'd14,
    OpPop      = 5'd15,
    OpResize   = 5'd17,
    OpAlloc    = 5'd18,                  // Freed array first, then a fresh one
    OpFree     = 5'd19,
    OpAdd      = 5'd20,                  // Returns the new value
    OpSubtract = 5'd22                   // Returns the new value
  } heapOpT;

  typedef enum logic [3:0] {
    ErrNone, ErrNotAllocated, ErrFreed, ErrOutOfBounds,
    ErrFull, ErrEmpty, ErrTooLarge, ErrOutOfMemory
  } heapErrT;

endpackage

`default_nettype wire

// ==== src/heapStorePkg.sv ====
//----------------------------------------------------------------------
// Storage geometry types of the heap memory
// Widths come from the heap parameter header
//----------------------------------------------------------------------
`default_nettype none

`include "heapMemory_params.svh"

package heapStorePkg;

  localparam int numArrays   = 2 ** `HEAP_ARRAY_BITS;
  localparam int arrayLength = 2 ** `HEAP_INDEX_BITS;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayIdT;
  typedef logic [`HEAP_INDEX_BITS-1:0] indexT;
  typedef logic [`HEAP_DATA_BITS-1:0]  dataT;

  // One bit wider than an index so a full array fits
  typedef logic [`HEAP_INDEX_BITS:0]   sizeT;

endpackage

`default_nettype wire

// ==== tb/heapMemory_props.sv ====
//----------------------------------------------------------------------
// Port properties of the heap memory, bound into every heapMemory
// Latency, quiet reset and a known error code on each result
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapMemory_props import heapOpPkg::*; (
  input logic    clock,
  input logic    resetN,
  input logic    start,
  input logic    done,
  input heapErrT error
);

  int failures = 0;

  // Fixed latency of two cycles, in both directions
  startToDone: assert property (@(posedge clock) disable iff (!resetN) start |-> ##2 done)
    else begin
      failures++;
      $error("done missing two cycles after start");
    end

  doneFromStart: assert property (@(posedge clock) disable iff (!resetN)
    done |-> $past(start, 2))
    else begin
      failures++;
      $error("done without a start two cycles earlier");
    end

  quietInReset: assert property (@(posedge clock) !resetN |-> !done)
    else begin
      failures++;
      $error("done high during reset");
    end

  knownError: assert property (@(posedge clock) disable iff (!resetN)
    done |-> !$isunknown(error))
    else begin
      failures++;
      $error("error code unknown while done is high");
    end

endmodule

bind heapMemory heapMemory_props props0 (.clock, .resetN, .start, .done, .error);

`default_nettype wire

// ==== tb/heapMemory_tb.sv ====
//----------------------------------------------------------------------
// Testbench for the heap memory: directed and random command streams
// Every result is checked against a behavioral heap model on done
//----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module heapMemory_tb import heapOpPkg::*, heapStorePkg::*; ();

  localparam int numDirected = 38;
  localparam int numRandom   = 600;
  localparam int cycleLimit  = 3 * (numDirected + numRandom) + 50;

  // Weighted op mix for the random stream
  localparam heapOpT opMix [16] = '{OpAlloc, OpAlloc, OpFree, OpWrite, OpWrite, OpWrite,
    OpRead, OpRead, OpSize, OpPush, OpPush, OpPop, OpResize, OpAdd, OpSubtract, OpClearAll};

  logic    clock, resetN, start, done;
  heapOpT  op;
  arrayIdT array;
  indexT   index;
  dataT    dataIn, dataOut;
  heapErrT error;

  // ----------------------------------------------------------------------
  // Heap model and expected results
  // ----------------------------------------------------------------------
  dataT    mem [numArrays][arrayLength] = '{default: '0};
  int      sizes [numArrays];
  bit      allocated [numArrays];
  bit      granted [numArrays];
  arrayIdT freedQ [$];                   // Back is the last freed
  int      fresh = 0;
  dataT    expData [$];
  heapErrT expErr [$];
  int      cycles = 0;

  heapMemory dut0 (.clock, .resetN, .start, .op, .array, .index, .dataIn,
                   .done, .dataOut, .error);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic fail();
    $display("TB FAILED");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic checkData(dataT expected);
    if (dataOut !== expected) begin
      $display("** Error: dataOut is 0x%h, expected 0x%h", dataOut, expected);
      fail();
    end
  endtask

  task automatic checkError(heapErrT expected);
    if (error !== expected) begin
      $display("** Error: error is 0x%h, expected 0x%h", error, expected);
      fail();
    end
  endtask

  task automatic predict(heapOpT o, arrayIdT a, indexT i, dataT d);
    heapErrT e;
    dataT    r;
    int      s;
    int      k;
    bit      needsLive;
    e = ErrNone;
    r = '0;
    s = sizes[a];
    needsLive = !(o inside {OpAlloc, OpClearAll});
    if (o == OpAlloc && freedQ.size() == 0 && fresh == numArrays) e = ErrOutOfMemory;
    else if (needsLive && !granted[a]) e = ErrNotAllocated;
    else if (needsLive && !allocated[a]) e = ErrFreed;
    else if (o inside {OpRead, OpAdd, OpSubtract} && i >= s) e = ErrOutOfBounds;
    else if (o == OpPush && s == arrayLength) e = ErrFull;
    else if (o == OpPop && s == 0) e = ErrEmpty;
    else if (o == OpResize && d > arrayLength) e = ErrTooLarge;
    if (e == ErrNone) begin
      case (o)
        OpClearAll: begin
          allocated = '{default: 1'b0};
          granted   = '{default: 1'b0};
          freedQ.delete();
          fresh = 0;
        end
        OpAlloc: begin
          if (freedQ.size() == 0) begin
            freedQ.push_back(arrayIdT'(fresh));  // Fresh array when none freed
            fresh++;
          end
          r = dataT'(freedQ.pop_back());
          allocated[r] = 1'b1;
          granted[r]   = 1'b1;
          sizes[r]     = 0;
        end
        OpFree: begin
          allocated[a] = 1'b0;
          freedQ.push_back(a);
        end
        OpWrite, OpPush: begin
          k = (o == OpPush) ? s : int'(i);
          mem[a][k] = d;
          if (k >= s) sizes[a] = k + 1;          // Write past the end extends
          r = d;
        end
        OpRead: r = mem[a][i];
        OpSize: r = dataT'(s);
        OpPop: begin
          sizes[a] = s - 1;
          r        = mem[a][s-1];
        end
        OpResize: begin
          sizes[a] = d;
          r        = d;
        end
        default: begin                           // Add and Subtract wrap
          mem[a][i] = (o == OpAdd) ? mem[a][i] + d : mem[a][i] - d;
          r         = mem[a][i];
        end
      endcase
    end
    expData.push_back(r);
    expErr.push_back(e);
  endtask

  task automatic issue(heapOpT o, arrayIdT a, indexT i, dataT d);
    @(posedge clock);
    start  <= 1'b1;
    op     <= o;
    array  <= a;
    index  <= i;
    dataIn <= d;
    predict(o, a, i, d);
  endtask

  task automatic idle();
    @(posedge clock);
    start <= 1'b0;
  endtask

  // Result compare and run limit
  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Timeout after %0d cycles with results still missing", cycles);
      fail();
    end else if (done && expData.size() == 0) begin
      $display("done pulsed with no command outstanding");
      fail();
    end else if (done) begin
      checkData(expData.pop_front());
      checkError(expErr.pop_front());
    end
  end

  initial begin
    arrayIdT a;
    heapOpT  o;
    dataT    d;
    void'($urandom(32'h7bc2e830));
    resetN = 1'b0;
    start  = 1'b0;
    op     = OpNone;
    array  = '0;
    index  = '0;
    dataIn = '0;
    repeat (4) @(posedge clock);
    resetN <= 1'b1;

    // ------------------------------------------------------------------
    // Directed allocation order and misuse
    // ------------------------------------------------------------------
    issue(OpRead, 0, 0, 0);                      // Never allocated
    repeat (5) issue(OpAlloc, 0, 0, 0);          // 0 to 3, then out of memory
    issue(OpFree, 2, 0, 0);
    issue(OpFree, 1, 0, 0);
    issue(OpFree, 1, 0, 0);                      // Already freed
    issue(OpWrite, 2, 0, 12'h05a);
    issue(OpAlloc, 0, 0, 0);                     // Last freed comes back first
    issue(OpClearAll, 0, 0, 0);
    issue(OpSize, 3, 0, 0);
    // Two arrays written, resized and read back
    repeat (2) issue(OpAlloc, 0, 0, 0);
    for (int k = 0; k < 3; k++) issue(OpWrite, 0, indexT'(k), dataT'(k));
    issue(OpResize, 0, 0, 3);
    for (int k = 0; k < 4; k++) issue(OpRead, 0, indexT'(k), 0);
    issue(OpSize, 0, 0, 0);
    issue(OpResize, 1, 0, 9);                    // Longer than an array
    issue(OpPop, 1, 0, 0);
    repeat (9) issue(OpPush, 1, 0, dataT'($urandom));
    issue(OpWrite, 1, 5, 12'hffe);
    issue(OpAdd, 1, 5, 12'h005);                 // Wraps past the top
    issue(OpSubtract, 1, 5, 12'h009);            // Wraps below zero

    // ------------------------------------------------------------------
    // Random stream, gaps and back-to-back starts
    // ------------------------------------------------------------------
    for (int n = 0; n < numRandom; n++) begin
      a = arrayIdT'($urandom);
      for (int t = 0; t < 3 && !allocated[a]; t++) a = arrayIdT'($urandom);
      o = opMix[$urandom_range(15, 0)];
      d = (o == OpResize) ? dataT'($urandom_range(9, 0)) : dataT'($urandom);
      if ($urandom_range(1, 0) == 1) idle();
      issue(o, a, indexT'($urandom), d);
    end
    idle();
    while (expData.size() != 0) @(posedge clock);
    repeat (4) @(posedge clock);                 // Catch a stray done

    if (dut0.props0.failures != 0) begin
      $display("%0d property failures reported", dut0.props0.failures);
      fail();
    end else begin
      $display("TB PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
